// File: source/mesh_defs.svh
/*
 * Configuration macros for the tile mesh
 * Coordinate, data, address and tag widths of a packet
 * Endpoint memory depth, link FIFO depth and mesh size
 */
`ifndef MESH_DEFS_SVH
`define MESH_DEFS_SVH

// Bits per x or y coordinate
`define MESH_COORD_W    2
`define MESH_DATA_W     32
`define MESH_MEM_WORDS  16
// Word address into the endpoint memory
`define MESH_ADDR_W     4
`define MESH_TAG_W      4

// Tiles per row and per column
`define MESH_COLS       2
`define MESH_ROWS       2
`define MESH_FIFO_DEPTH 2

`endif

// File: source/mesh_noc_pkg.sv
/*
 * Mesh fabric package
 * Port direction enumeration and the tile coordinate type
 */
`default_nettype none

`include "mesh_defs.svh"

package mesh_noc_pkg;

  // Local port plus four compass links
  localparam int NUM_DIRS = 5;

  // Port indices of a router, P is the tile's own endpoint
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  // Tile position, x grows east and y grows north
  typedef struct packed {
    logic [`MESH_COORD_W-1:0] x;
    logic [`MESH_COORD_W-1:0] y;
  } coord_t;

endpackage

`default_nettype wire

// File: source/mesh_packet_pkg.sv
/*
 * Packet package
 * Request and reply opcodes, the packet carried on a link,
 * and the forward link struct with its valid bit
 */
`default_nettype none

`include "mesh_defs.svh"

package mesh_packet_pkg;
  import mesh_noc_pkg::*;

  typedef enum logic [1:0] {
    LOAD        = 2'd0,
    STORE       = 2'd1,
    LOAD_REPLY  = 2'd2,
    STORE_REPLY = 2'd3
  } op_e;

  // 50 bits in total
  typedef struct packed {
    coord_t                  dst;   // Routing uses only this field
    coord_t                  src;   // Where the reply goes back to
    op_e                     op;
    logic [`MESH_TAG_W-1:0]  tag;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
  } packet_t;

  // Forward half of a link, ready travels back as its own bit
  typedef struct packed {
    logic    valid;
    packet_t pkt;
  } link_t;

endpackage

`default_nettype wire

// File: source/link_fifo.sv
/*
 * Link input buffer
 * Two-entry circular FIFO with valid/ready on both sides,
 * payload chosen by a type parameter
 */
`timescale 1ns/10ps
`default_nettype none

`include "mesh_defs.svh"

module link_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  localparam int DEPTH = `MESH_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  payload_t         slot_q [DEPTH];  // No reset, valid comes from the count
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (count_q == (PTR_W+1)'(DEPTH));
  assign empty = (count_q == '0);
  assign push  = in_valid_i && !full;
  assign pop   = out_ready_i && !empty;

  // Ready depends only on our own state, so no path from out_ready_i
  assign in_ready_o  = !full;
  assign out_valid_o = !empty;
  assign out_data_o  = slot_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) slot_q[wr_ptr_q] <= in_data_i;
  end

  // The count stays within the depth and agrees with the two pointers
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (count_q <= (PTR_W+1)'(DEPTH)) && ((wr_ptr_q == rd_ptr_q) == (empty || full)));

  // A stalled head stays put until it is taken
  a_head_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));

endmodule

`default_nettype wire

// File: source/mesh_router.sv
/*
 * Five-port dimension-ordered mesh router
 * One link FIFO per input, XY route computed at each FIFO head,
 * round-robin arbiter and registered stage per output
 */
`timescale 1ns/10ps
`default_nettype none

module mesh_router
  import mesh_noc_pkg::*;
  import mesh_packet_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  coord_t        my_coord_i,
  input  link_t [S:P]   links_i,
  output logic  [S:P]   links_ready_o,
  output link_t [S:P]   links_o,
  input  logic  [S:P]   links_ready_i
);

  // X first, then Y; north has the larger y
  function automatic dir_e route_dir(coord_t dst, coord_t here);
    if (dst.x < here.x) return W;
    if (dst.x > here.x) return E;
    if (dst.y < here.y) return S;
    if (dst.y > here.y) return N;
    return P;
  endfunction

  logic [NUM_DIRS-1:0] fifo_valid;
  logic [NUM_DIRS-1:0] fifo_pop;
  packet_t             fifo_pkt [NUM_DIRS];
  dir_e                head_dir [NUM_DIRS];

  logic [NUM_DIRS-1:0] gnt      [NUM_DIRS];  // One-hot input grant per output
  logic [2:0]          win_idx  [NUM_DIRS];
  packet_t             sel_pkt  [NUM_DIRS];
  logic [NUM_DIRS-1:0] out_load;
  logic [2:0]          rr_ptr_q [NUM_DIRS];  // Input with top priority next round
  logic [NUM_DIRS-1:0] out_valid_q;
  packet_t             out_pkt_q [NUM_DIRS];

  for (genvar d = 0; d < NUM_DIRS; d++) begin : g_port
    link_fifo #(
      .payload_t(packet_t)
    ) u_in_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_valid_i (links_i[d].valid),
      .in_data_i  (links_i[d].pkt),
      .in_ready_o (links_ready_o[d]),
      .out_valid_o(fifo_valid[d]),
      .out_data_o (fifo_pkt[d]),
      .out_ready_i(fifo_pop[d])
    );

    assign head_dir[d] = route_dir(fifo_pkt[d].dst, my_coord_i);
    assign links_o[d]  = '{valid: out_valid_q[d], pkt: out_pkt_q[d]};

    // What leaves through a port must have been routed to that port
    a_route_ok: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      out_valid_q[d] |-> (route_dir(out_pkt_q[d].dst, my_coord_i) == dir_e'(d)));
  end

  // Search from the pointer upward and take the first head that wants this output
  always_comb begin
    int idx;
    for (int o = 0; o < NUM_DIRS; o++) begin
      gnt[o]     = '0;
      win_idx[o] = '0;
      sel_pkt[o] = fifo_pkt[0];
      for (int k = 0; k < NUM_DIRS; k++) begin
        idx = int'(rr_ptr_q[o]) + k;
        if (idx >= NUM_DIRS) idx = idx - NUM_DIRS;
        if (fifo_valid[idx] && head_dir[idx] == dir_e'(o) && gnt[o] == '0) begin
          gnt[o][idx] = 1'b1;
          win_idx[o]  = 3'(idx);
          sel_pkt[o]  = fifo_pkt[idx];
        end
      end
      // The output stage takes a packet when empty or draining this cycle
      out_load[o] = (gnt[o] != '0) && (!out_valid_q[o] || links_ready_i[o]);
    end
  end

  // Each head asks for one output only, so at most one grant per input
  always_comb begin
    fifo_pop = '0;
    for (int o = 0; o < NUM_DIRS; o++) begin
      for (int i = 0; i < NUM_DIRS; i++) begin
        if (gnt[o][i] && out_load[o]) fifo_pop[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= '0;
      for (int o = 0; o < NUM_DIRS; o++) rr_ptr_q[o] <= '0;
    end else begin
      for (int o = 0; o < NUM_DIRS; o++) begin
        if (out_load[o]) begin
          out_valid_q[o] <= 1'b1;
          rr_ptr_q[o]    <= (win_idx[o] == 3'(NUM_DIRS - 1)) ? '0 : win_idx[o] + 3'd1;
        end else if (links_ready_i[o]) begin
          out_valid_q[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NUM_DIRS; o++) begin
      if (out_load[o]) out_pkt_q[o] <= sel_pkt[o];
    end
  end

endmodule

`default_nettype wire

// File: source/mem_endpoint.sv
/*
 * Tile endpoint socket
 * Serves remote LOAD and STORE packets on a small data memory
 * and returns one reply per request through a reply register
 */
`timescale 1ns/10ps
`default_nettype none

`include "mesh_defs.svh"

module mem_endpoint
  import mesh_noc_pkg::*;
  import mesh_packet_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  coord_t my_coord_i,
  input  link_t  req_i,
  output logic   req_ready_o,
  output link_t  rsp_o,
  input  logic   rsp_ready_i
);

  logic [`MESH_DATA_W-1:0] mem_q [`MESH_MEM_WORDS];
  logic                    rsp_valid_q;
  packet_t                 rsp_pkt_q;
  logic                    req_fire;
  logic                    is_store;

  // Accept when the reply slot is free or emptying right now
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign req_fire    = req_i.valid && req_ready_o;
  assign is_store    = (req_i.pkt.op == STORE);

  assign rsp_o = '{valid: rsp_valid_q, pkt: rsp_pkt_q};

  // Memory comes out of reset all zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `MESH_MEM_WORDS; i++) mem_q[i] <= '0;
    end else if (req_fire && is_store) begin
      mem_q[req_i.pkt.addr] <= req_i.pkt.data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      rsp_pkt_q.dst  <= req_i.pkt.src;   // Back to whoever asked
      rsp_pkt_q.src  <= my_coord_i;
      rsp_pkt_q.op   <= is_store ? STORE_REPLY : LOAD_REPLY;
      rsp_pkt_q.tag  <= req_i.pkt.tag;
      rsp_pkt_q.addr <= req_i.pkt.addr;
      rsp_pkt_q.data <= is_store ? '0 : mem_q[req_i.pkt.addr];
    end
  end

  // Replies never route to an endpoint, only requests do
  a_req_op: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.valid |-> (req_i.pkt.op inside {LOAD, STORE}));

endmodule

`default_nettype wire

// File: source/mesh_tile.sv
/*
 * Mesh tile
 * Local reset synchronizer, XY router and memory endpoint
 * joined on the router's P port
 */
`timescale 1ns/10ps
`default_nettype none

module mesh_tile
  import mesh_noc_pkg::*;
  import mesh_packet_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  coord_t        my_coord_i,
  input  link_t [S:W]   links_i,
  output logic  [S:W]   links_ready_o,
  output link_t [S:W]   links_o,
  input  logic  [S:W]   links_ready_i
);

  logic [1:0]  rst_sync_q;
  logic        rst_local_n;
  link_t       ep_req;
  link_t       ep_rsp;
  logic        ep_req_ready;
  logic        ep_rsp_ready;
  link_t [S:P] rtr_in;
  link_t [S:P] rtr_out;
  logic  [S:P] rtr_ready_in;
  logic  [S:P] rtr_ready_out;

  // The mesh reset reaches tiles late, so each tile re-times its own copy.
  // Assertion is immediate, release waits for two local edges
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) rst_sync_q <= '0;
    else          rst_sync_q <= {rst_sync_q[0], 1'b1};
  end
  assign rst_local_n = rst_sync_q[1];

  // Endpoint sits on P, the compass links fill W..S
  assign rtr_in        = {links_i, ep_rsp};
  assign rtr_ready_in  = {links_ready_i, ep_req_ready};
  assign links_o       = rtr_out[S:W];
  assign links_ready_o = rtr_ready_out[S:W];
  assign ep_req        = rtr_out[P];
  assign ep_rsp_ready  = rtr_ready_out[P];

  mesh_router u_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_local_n),
    .my_coord_i   (my_coord_i),
    .links_i      (rtr_in),
    .links_ready_o(rtr_ready_out),
    .links_o      (rtr_out),
    .links_ready_i(rtr_ready_in)
  );

  mem_endpoint u_endpoint (
    .clk_i      (clk_i),
    .rst_n_i    (rst_local_n),
    .my_coord_i (my_coord_i),
    .req_i      (ep_req),
    .req_ready_o(ep_req_ready),
    .rsp_o      (ep_rsp),
    .rsp_ready_i(ep_rsp_ready)
  );

endmodule

`default_nettype wire

// File: source/mesh_array.sv
/*
 * Top level mesh of tiles
 * Tiles at x=1..2, y=0..1 with neighbour links crossed,
 * host link on the west side of tile (1,0), other edges stubbed
 */
`timescale 1ns/10ps
`default_nettype none

`include "mesh_defs.svh"

module mesh_array
  import mesh_noc_pkg::*;
  import mesh_packet_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  link_t host_req_i,
  output logic  host_req_ready_o,
  output link_t host_rsp_o,
  input  logic  host_rsp_ready_i
);

  // Indexed [column][row], column 0 is x=1
  wire link_t [S:W] t_in     [`MESH_COLS][`MESH_ROWS];
  wire link_t [S:W] t_out    [`MESH_COLS][`MESH_ROWS];
  wire        [S:W] t_rdy_in [`MESH_COLS][`MESH_ROWS];
  wire        [S:W] t_rdy_out[`MESH_COLS][`MESH_ROWS];

  assign host_req_ready_o = t_rdy_out[0][0][W];
  assign host_rsp_o       = t_out[0][0][W];

  for (genvar c = 0; c < `MESH_COLS; c++) begin : g_col
    for (genvar r = 0; r < `MESH_ROWS; r++) begin : g_row
      mesh_tile u_tile (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .my_coord_i   ('{x: `MESH_COORD_W'(c + 1), y: `MESH_COORD_W'(r)}),
        .links_i      (t_in[c][r]),
        .links_ready_o(t_rdy_out[c][r]),
        .links_o      (t_out[c][r]),
        .links_ready_i(t_rdy_in[c][r])
      );

      if (c > 0) begin : g_w_link
        assign t_in[c][r][W]     = t_out[c-1][r][E];
        assign t_rdy_in[c][r][W] = t_rdy_out[c-1][r][E];
      end else if (r == 0) begin : g_w_host     // Host owns (0,0) to the west
        assign t_in[c][r][W]     = host_req_i;
        assign t_rdy_in[c][r][W] = host_rsp_ready_i;
      end else begin : g_w_stub
        assign t_in[c][r][W]     = '0;
        assign t_rdy_in[c][r][W] = 1'b1;
      end

      if (c < `MESH_COLS - 1) begin : g_e_link
        assign t_in[c][r][E]     = t_out[c+1][r][W];
        assign t_rdy_in[c][r][E] = t_rdy_out[c+1][r][W];
      end else begin : g_e_stub
        assign t_in[c][r][E]     = '0;
        assign t_rdy_in[c][r][E] = 1'b1;
      end

      if (r < `MESH_ROWS - 1) begin : g_n_link
        assign t_in[c][r][N]     = t_out[c][r+1][S];
        assign t_rdy_in[c][r][N] = t_rdy_out[c][r+1][S];
      end else begin : g_n_stub
        assign t_in[c][r][N]     = '0;
        assign t_rdy_in[c][r][N] = 1'b1;
      end

      if (r > 0) begin : g_s_link
        assign t_in[c][r][S]     = t_out[c][r-1][N];
        assign t_rdy_in[c][r][S] = t_rdy_out[c][r-1][N];
      end else begin : g_s_stub
        assign t_in[c][r][S]     = '0;
        assign t_rdy_in[c][r][S] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/mesh_array_tb.sv
/*
 * Testbench for the tile mesh
 * Request table built against a memory model, host driver on the west link
 * of tile (1,0), reply checker matched by source and tag, and a watchdog
 */
`timescale 1ns/10ps
`default_nettype none

`include "mesh_defs.svh"

module mesh_array_tb
  import mesh_noc_pkg::*;
  import mesh_packet_pkg::*;
();

  // Replies from row 1 turn west at x=1 and leave through the stubbed edge
  // of (1,1), so the host only exchanges packets with (1,0) and (2,0)
  localparam int NUM_TILES = 2;
  localparam int NUM_TAGS  = 1 << `MESH_TAG_W;

  typedef struct packed {
    logic [2:0]              test;
    logic                    tile;         // 0 is (1,0), 1 is (2,0)
    logic                    reset_first;  // Pulse reset before this row
    op_e                     op;
    logic [`MESH_TAG_W-1:0]  tag;
    logic [`MESH_ADDR_W-1:0] addr;
    logic [`MESH_DATA_W-1:0] data;
    logic [`MESH_DATA_W-1:0] exp_data;
  } row_t;

  logic  clk;
  logic  rst_n;
  link_t host_req;
  logic  host_req_ready;
  link_t host_rsp;
  logic  host_rsp_ready;

  row_t                    table_q [$];
  logic [`MESH_DATA_W-1:0] model_mem [NUM_TILES][`MESH_MEM_WORDS];
  int                      next_tag [NUM_TILES];
  row_t                    open_req [NUM_TILES][NUM_TAGS];
  logic                    open_busy [NUM_TILES][NUM_TAGS];
  logic [31:0]             rng_state;
  int                      outstanding;
  int                      errors;
  int                      replies;
  logic                    table_built;
  logic                    stall_active;
  logic                    saw_backpressure;

  mesh_array uut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .host_req_i      (host_req),
    .host_req_ready_o(host_req_ready),
    .host_rsp_o      (host_rsp),
    .host_rsp_ready_i(host_rsp_ready)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic draw(output logic [31:0] w);
    rng_state = xorshift32(rng_state);
    w = rng_state;
  endtask

  function automatic string test_name(input int t);
    case (t)
      1:       return "loads after reset";
      2:       return "store then load";
      3:       return "back-to-back requests";
      4:       return "reply back-pressure";
      default: return "reset mid-run";
    endcase
  endfunction

  // Expected data follows the memory model in issue order
  task automatic add_row(input logic [2:0] test, input logic tile, input op_e op,
                         input logic [`MESH_ADDR_W-1:0] addr,
                         input logic [`MESH_DATA_W-1:0] data, input logic reset_first);
    row_t r;
    if (reset_first) begin
      foreach (model_mem[t, a]) model_mem[t][a] = '0;
    end
    r.test        = test;
    r.tile        = tile;
    r.reset_first = reset_first;
    r.op          = op;
    r.tag         = `MESH_TAG_W'(next_tag[tile]);
    r.addr        = addr;
    r.data        = data;
    r.exp_data    = (op == STORE) ? '0 : model_mem[tile][addr];
    if (op == STORE) model_mem[tile][addr] = data;
    next_tag[tile] = (next_tag[tile] + 1) % NUM_TAGS;
    table_q.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] w;
    logic [31:0] d;
    foreach (model_mem[t, a]) model_mem[t][a] = '0;
    foreach (next_tag[t]) next_tag[t] = 0;
    for (int t = 0; t < NUM_TILES; t++) begin
      for (int a = 0; a < `MESH_MEM_WORDS; a++) begin
        add_row(3'd1, t[0], LOAD, `MESH_ADDR_W'(a), '0, 1'b0);
      end
    end
    for (int t = 0; t < NUM_TILES; t++) begin
      for (int k = 0; k < 4; k++) begin
        draw(w);
        draw(d);
        add_row(3'd2, t[0], STORE, w[`MESH_ADDR_W-1:0], d, 1'b0);
        add_row(3'd2, t[0], LOAD, w[`MESH_ADDR_W-1:0], '0, 1'b0);
      end
    end
    for (int k = 0; k < 16; k++) begin
      draw(w);
      draw(d);
      add_row(3'd3, w[8], w[9] ? STORE : LOAD, w[`MESH_ADDR_W-1:0], d, 1'b0);
    end
    // Stores to words 8..13 of both tiles, then loads of the same words
    for (int k = 0; k < 24; k++) begin
      draw(d);
      add_row(3'd4, k[0], (k < 12) ? STORE : LOAD, `MESH_ADDR_W'(8 + (k % 12) / 2), d, 1'b0);
    end
    for (int t = 0; t < NUM_TILES; t++) begin
      draw(d);
      add_row(3'd5, t[0], STORE, `MESH_ADDR_W'(1), d, 1'b0);
      draw(d);
      add_row(3'd5, t[0], STORE, `MESH_ADDR_W'(2), d, 1'b0);
    end
    for (int t = 0; t < NUM_TILES; t++) begin
      for (int a = 0; a < 4; a++) begin
        add_row(3'd5, t[0], LOAD, `MESH_ADDR_W'(a), '0, (t == 0 && a == 0));
      end
    end
  endtask

  task automatic issue_row(input row_t r);
    while (open_busy[r.tile][r.tag]) @(negedge clk);  // Tag still in flight
    open_req[r.tile][r.tag]  = r;
    open_busy[r.tile][r.tag] = 1'b1;
    outstanding++;
    host_req.valid    = 1'b1;
    host_req.pkt.dst  = '{x: `MESH_COORD_W'(r.tile) + `MESH_COORD_W'(1), y: '0};
    host_req.pkt.src  = '0;                          // The host owns (0,0)
    host_req.pkt.op   = r.op;
    host_req.pkt.tag  = r.tag;
    host_req.pkt.addr = r.addr;
    host_req.pkt.data = r.data;
    while (!host_req_ready) @(negedge clk);  // Ready only moves on a rising edge
    @(negedge clk);
    host_req.valid = 1'b0;
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAILED %0d ns: %s is %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic check_reply(input packet_t p);
    int   t;
    row_t r;
    op_e  exp_op;
    if (p.src.y != '0 || p.src.x == '0 || p.src.x > `MESH_COORD_W'(NUM_TILES)) begin
      $display("%0d ns: reply from tile (%0d,%0d), which was never addressed",
               $time, p.src.x, p.src.y);
      errors++;
      return;
    end
    t = int'(p.src.x) - 1;
    if (!open_busy[t][p.tag]) begin
      $display("%0d ns: reply from (%0d,0) tag %0d matches no open request",
               $time, p.src.x, p.tag);
      errors++;
      return;
    end
    r = open_req[t][p.tag];
    open_busy[t][p.tag] = 1'b0;
    outstanding--;
    replies++;
    exp_op = (r.op == STORE) ? STORE_REPLY : LOAD_REPLY;
    if (p.dst != '0) report_mismatch("reply destination", 32'(p.dst), 32'h0);
    if (p.op != exp_op) begin
      report_mismatch($sformatf("tile %0d tag %0d opcode", t, p.tag), 32'(p.op),
                      32'(exp_op));
    end
    if (p.addr != r.addr) begin
      report_mismatch($sformatf("tile %0d tag %0d address", t, p.tag), 32'(p.addr),
                      32'(r.addr));
    end
    if (p.data != r.exp_data) begin
      report_mismatch($sformatf("tile %0d tag %0d data", t, p.tag), p.data,
                      r.exp_data);
    end
  endtask

  always @(posedge clk) begin
    if (stall_active && host_req.valid && !host_req_ready) saw_backpressure = 1'b1;
    if (host_rsp.valid && host_rsp_ready) check_reply(host_rsp.pkt);
  end

  task automatic pulse_reset();
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);  // Tile synchronizers release two edges later
  endtask

  task automatic wait_drain();
    while (outstanding != 0) @(negedge clk);
    repeat (10) @(negedge clk);  // Room for a duplicate to show up
  endtask

  initial begin
    int   err_before;
    int   rsp_before;
    row_t r;
    clk              = 1'b0;
    rst_n            = 1'b0;
    host_req         = '0;
    host_rsp_ready   = 1'b1;
    rng_state        = 32'd95;
    outstanding      = 0;
    errors           = 0;
    replies          = 0;
    stall_active     = 1'b0;
    saw_backpressure = 1'b0;
    table_built      = 1'b0;
    foreach (open_busy[t, g]) open_busy[t][g] = 1'b0;
    build_table();
    table_built = 1'b1;
    pulse_reset();
    for (int t = 1; t <= 5; t++) begin
      err_before = errors;
      rsp_before = replies;
      if (t == 4) begin
        host_rsp_ready = 1'b0;
        stall_active   = 1'b1;
        fork
          begin
            repeat (50) @(negedge clk);
            host_rsp_ready = 1'b1;
            stall_active   = 1'b0;
          end
        join_none
      end
      foreach (table_q[i]) begin
        r = table_q[i];
        if (r.test == 3'(t)) begin
          if (r.reset_first) begin
            wait_drain();
            host_rsp_ready = 1'b0;  // Park one reply at the host port
            issue_row(r);
            while (!host_rsp.valid) @(negedge clk);
            pulse_reset();
            open_busy[r.tile][r.tag] = 1'b0;  // The parked reply is gone with the reset
            outstanding--;
            host_rsp_ready = 1'b1;
            repeat (8) begin
              @(posedge clk);
              if (host_rsp.valid) begin
                $display("%0d ns: reply valid seen after reset with no request sent", $time);
                errors++;
              end
            end
            @(negedge clk);
          end
          issue_row(r);
        end
      end
      wait_drain();
      if (t == 4 && !saw_backpressure) begin
        $display("Host request ready never dropped while replies were held back");
        errors++;
      end
      $display("test %0d %s: %0d replies, %0d errors", t, test_name(t),
               replies - rsp_before, errors - err_before);
    end
    $display("5 tests, %0d requests, %0d replies, %0d errors", table_q.size(), replies, errors);
    if (errors == 0) $display("Test passed");
    else $display("Test failed");
    $finish;
  end

  // Generous budget of 200 cycles per table row
  initial begin
    int limit;
    wait (table_built);
    limit = table_q.size() * 200;
    repeat (limit) @(posedge clk);
    $display("Timeout after %0d cycles with %0d replies still missing", limit, outstanding);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: mesh_array.f
+incdir+source
source/mesh_noc_pkg.sv
source/mesh_packet_pkg.sv
source/link_fifo.sv
source/mesh_router.sv
source/mem_endpoint.sv
source/mesh_tile.sv
source/mesh_array.sv
verif/mesh_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the mesh testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mesh_array_tb -f mesh_array.f -o mesh_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/mesh_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
exit 0
